/* project.f */
+incdir+common
common/dm_pkg.sv
common/harness_pkg.sv
hw/dmi_port_mux.sv
hw/rst_sync.sv
hw/debug_req_gate.sv
dmi_target/dmi_ctrl_fsm.sv
dmi_target/dm_regs.sv
hw/dbg_harness_top.sv
verification/tb_clk_gen.sv
verification/tb_top.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and report the result through the exit status

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal --top-module tb_top -f project.f -o sim_tb_top; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_tb_top)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Test completed successfully"; then
  exit 0
fi

echo "Pass message not found in simulation output"
exit 1

/* verification/tb_top.sv */
// Inputs change on falling edges and outputs are sampled there; data registers start unknown
`timescale 1ns/1ps

`include "harness_defs.svh"

module tb_top;

  localparam int unsigned XferCount  = 40;
  localparam int unsigned XferCycles = 12;
  localparam int unsigned RunCycles  = 16 + `DMI_DEL_CYCLES + XferCount * XferCycles;

  localparam logic [31:0] Dmactive = 32'd1 << `BIT_DMACTIVE;
  localparam logic [31:0] Ndmreset = 32'd1 << `BIT_NDMRESET;
  localparam logic [31:0] Haltreq  = 32'd1 << `BIT_HALTREQ;
  localparam logic [31:0] CtrlMask = Dmactive | Ndmreset | Haltreq;

  logic                  clk;
  logic                  rst_n;
  harness_pkg::dmi_src_e src_sel;
  logic                  jtag_req_valid;
  dm_pkg::dmi_req_t      jtag_req;
  logic                  jtag_req_ready;
  logic                  jtag_resp_valid;
  dm_pkg::dmi_resp_t     jtag_resp;
  logic                  jtag_resp_ready;
  logic                  dtm_req_valid;
  dm_pkg::dmi_req_t      dtm_req;
  logic                  dtm_req_ready;
  logic                  dtm_resp_valid;
  dm_pkg::dmi_resp_t     dtm_resp;
  logic                  dtm_resp_ready;
  logic                  debug_req;
  logic                  sys_rst_n;

  int                errors;
  int                tests;
  int                test_err0;
  int                cyc;
  int                seed;
  logic [31:0]       ref_data [4];
  logic [31:0]       ref_ctrl;
  dm_pkg::dmi_resp_t expect_q [$];
  logic              jtag_valid_q;
  logic              dtm_valid_q;

  tb_clk_gen i_clk_gen (
    .clk_o  ( clk   ),
    .rst_no ( rst_n )
  );

  dbg_harness_top DUT (
    .clk_i             ( clk             ),
    .rst_ni            ( rst_n           ),
    .src_sel_i         ( src_sel         ),
    .jtag_req_valid_i  ( jtag_req_valid  ),
    .jtag_req_i        ( jtag_req        ),
    .jtag_req_ready_o  ( jtag_req_ready  ),
    .jtag_resp_valid_o ( jtag_resp_valid ),
    .jtag_resp_o       ( jtag_resp       ),
    .jtag_resp_ready_i ( jtag_resp_ready ),
    .dtm_req_valid_i   ( dtm_req_valid   ),
    .dtm_req_i         ( dtm_req         ),
    .dtm_req_ready_o   ( dtm_req_ready   ),
    .dtm_resp_valid_o  ( dtm_resp_valid  ),
    .dtm_resp_o        ( dtm_resp        ),
    .dtm_resp_ready_i  ( dtm_resp_ready  ),
    .debug_req_o       ( debug_req       ),
    .sys_rst_no        ( sys_rst_n       )
  );

  // ----------------------------------------
  // Reference model of the register block
  // ----------------------------------------
  function automatic dm_pkg::dmi_resp_t ref_resp(input dm_pkg::dmi_req_t req);
    dm_pkg::dmi_resp_t r;
    logic              in_data;
    r.data  = '0;
    r.resp  = dm_pkg::DMI_OK;
    // data0..data3 sit at 0x04..0x07 and the low address bits pick the word
    in_data = (req.addr >= `ADDR_DATA0) && (req.addr < `ADDR_DATA0 + 7'd4);
    if (req.op == dm_pkg::DTM_RSVD) begin
      r.resp = dm_pkg::DMI_FAILED;
    end else if (req.op == dm_pkg::DTM_READ) begin
      if (req.addr == `ADDR_DMCONTROL) r.data = ref_ctrl;
      else if (in_data) r.data = ref_data[req.addr[1:0]];
    end else if (req.op == dm_pkg::DTM_WRITE) begin
      if (req.addr == `ADDR_DMCONTROL) ref_ctrl = req.data & CtrlMask;
      else if (in_data) ref_data[req.addr[1:0]] = req.data;
    end
    return r;
  endfunction

  // ----------------------------------------
  // Compare tasks
  // ----------------------------------------
  task automatic check_resp(input string what, input dm_pkg::dmi_resp_t act,
                            input dm_pkg::dmi_resp_t exp);
    if (act !== exp) begin
      $display("ERROR %0t: %s got data %h code %0d, expected data %h code %0d",
               $time, what, act.data, act.resp, exp.data, exp.resp);
      errors++;
    end
  endtask

  task automatic check_bit(input string what, input logic act, input logic exp);
    if (act !== exp) begin
      $display("ERROR %0t: %s is %b, expected %b", $time, what, act, exp);
      errors++;
    end
  endtask

  function automatic logic req_ready_of(input harness_pkg::dmi_src_e src);
    return (src == harness_pkg::SRC_JTAG) ? jtag_req_ready : dtm_req_ready;
  endfunction

  function automatic logic resp_valid_of(input harness_pkg::dmi_src_e src);
    return (src == harness_pkg::SRC_JTAG) ? jtag_resp_valid : dtm_resp_valid;
  endfunction

  function automatic dm_pkg::dmi_resp_t resp_of(input harness_pkg::dmi_src_e src);
    return (src == harness_pkg::SRC_JTAG) ? jtag_resp : dtm_resp;
  endfunction

  task automatic drive_req(input harness_pkg::dmi_src_e src, input logic valid,
                           input dm_pkg::dmi_req_t req);
    if (src == harness_pkg::SRC_JTAG) begin
      jtag_req_valid = valid;
      jtag_req       = req;
    end else begin
      dtm_req_valid = valid;
      dtm_req       = req;
    end
  endtask

  task automatic set_resp_ready(input harness_pkg::dmi_src_e src, input logic ready);
    if (src == harness_pkg::SRC_JTAG) jtag_resp_ready = ready;
    else dtm_resp_ready = ready;
  endtask

  // ----------------------------------------
  // One DMI transfer with optional back-pressure
  // ----------------------------------------
  task automatic dmi_xfer(input harness_pkg::dmi_src_e src, input dm_pkg::dtm_op_e op,
                          input logic [`DMI_ADDR_W-1:0] addr,
                          input logic [`DMI_DATA_W-1:0] data, input int bp_cycles);
    dm_pkg::dmi_req_t  req;
    dm_pkg::dmi_resp_t held;
    int                waited;
    req.addr = addr;
    req.op   = op;
    req.data = data;
    @(negedge clk);
    src_sel = src;
    drive_req(src, 1'b1, req);
    waited = 0;
    while (!req_ready_of(src) && waited < 20) begin
      @(negedge clk);
      waited++;
    end
    if (!req_ready_of(src)) begin
      $display("Request to address %h was never accepted", addr);
      errors++;
      drive_req(src, 1'b0, '0);
      return;
    end
    expect_q.push_back(ref_resp(req));
    // Accepted on the rising edge just passed
    @(negedge clk);
    drive_req(src, 1'b0, '0);
    waited = 1;
    while (!resp_valid_of(src) && waited < 20) begin
      @(negedge clk);
      waited++;
    end
    if (!resp_valid_of(src)) begin
      $display("No response arrived for the request to address %h", addr);
      errors++;
      return;
    end
    if (waited != 1) begin
      $display("ERROR %0t: response came %0d cycles after acceptance, expected 1",
               $time, waited);
      errors++;
    end
    // Both transports see the target busy
    check_bit("jtag req ready while busy", jtag_req_ready, 1'b0);
    check_bit("dtm req ready while busy", dtm_req_ready, 1'b0);
    held = resp_of(src);
    repeat (bp_cycles) begin
      @(negedge clk);
      check_resp("response under back-pressure", resp_of(src), held);
      check_bit("req ready under back-pressure", req_ready_of(src), 1'b0);
      check_bit("resp valid under back-pressure", resp_valid_of(src), 1'b1);
    end
    set_resp_ready(src, 1'b1);
    @(negedge clk);
    set_resp_ready(src, 1'b0);
    check_bit("resp valid after handshake", resp_valid_of(src), 1'b0);
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("%s done, %0d errors", name, errors - test_err0);
    test_err0 = errors;
  endtask

  // Counts rising edges since rst_ni rose
  always @(posedge clk) begin
    if (!rst_n) cyc <= 0;
    else cyc <= cyc + 1;
  end

  // ----------------------------------------
  // Compare process
  // ----------------------------------------
  always @(negedge clk) begin
    if (rst_n) begin
      if (src_sel == harness_pkg::SRC_JTAG) begin
        check_bit("dtm resp valid while JTAG owns the target", dtm_resp_valid, 1'b0);
      end else begin
        check_bit("jtag resp valid while DTM owns the target", jtag_resp_valid, 1'b0);
      end
      if ((jtag_resp_valid && !jtag_valid_q) || (dtm_resp_valid && !dtm_valid_q)) begin
        if (expect_q.size() == 0) begin
          $display("A response appeared with no request outstanding");
          errors++;
        end else begin
          check_resp("DMI response", resp_of(src_sel), expect_q.pop_front());
        end
      end
    end
    jtag_valid_q = jtag_resp_valid;
    dtm_valid_q  = dtm_resp_valid;
  end

  // Bounded by the transfer budget plus the gating window
  initial begin
    repeat (2 * RunCycles) @(posedge clk);
    $display("Watchdog expired before the tests finished");
    $display("Test failed");
    $finish;
  end

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  initial begin
    logic [31:0] wdata;
    int          waited;
    src_sel         = harness_pkg::SRC_DTM;
    jtag_req_valid  = 1'b0;
    jtag_req        = '0;
    jtag_resp_ready = 1'b0;
    dtm_req_valid   = 1'b0;
    dtm_req         = '0;
    dtm_resp_ready  = 1'b0;
    jtag_valid_q    = 1'b0;
    dtm_valid_q     = 1'b0;
    ref_ctrl        = '0;
    errors          = 0;
    tests           = 0;
    test_err0       = 0;
    seed            = 32'h2fc8;

    @(negedge clk);
    check_bit("req ready in reset", dtm_req_ready, 1'b1);
    check_bit("jtag req ready in reset", jtag_req_ready, 1'b1);
    check_bit("jtag resp valid in reset", jtag_resp_valid, 1'b0);
    check_bit("dtm resp valid in reset", dtm_resp_valid, 1'b0);
    check_bit("debug_req_o in reset", debug_req, 1'b0);
    check_bit("sys_rst_no in reset", sys_rst_n, 1'b0);
    while (!rst_n) @(negedge clk);
    end_test("reset state");

    // Halt request must wait out the window counted from rst_ni
    dmi_xfer(harness_pkg::SRC_DTM, dm_pkg::DTM_WRITE, `ADDR_DMCONTROL, Dmactive | Haltreq, 0);
    while (cyc < `DMI_DEL_CYCLES + 8) begin
      @(negedge clk);
      check_bit("debug_req_o during gating", debug_req, cyc >= `DMI_DEL_CYCLES);
    end
    dmi_xfer(harness_pkg::SRC_DTM, dm_pkg::DTM_WRITE, `ADDR_DMCONTROL, Dmactive, 0);
    check_bit("debug_req_o after haltreq clears", debug_req, 1'b0);
    dmi_xfer(harness_pkg::SRC_DTM, dm_pkg::DTM_WRITE, `ADDR_DMCONTROL, Haltreq, 0);
    check_bit("debug_req_o without dmactive", debug_req, 1'b0);
    end_test("halt gating");

    for (int i = 0; i < 4; i++) begin
      wdata = $random(seed);
      dmi_xfer(harness_pkg::SRC_DTM, dm_pkg::DTM_WRITE, `ADDR_DATA0 + 7'(i), wdata, 0);
    end
    for (int i = 0; i < 4; i++) begin
      dmi_xfer(harness_pkg::SRC_DTM, dm_pkg::DTM_READ, `ADDR_DATA0 + 7'(i), 32'h0, 0);
    end
    end_test("data registers");

    for (int i = 2; i < 4; i++) begin
      wdata = $random(seed);
      dmi_xfer(harness_pkg::SRC_JTAG, dm_pkg::DTM_WRITE, `ADDR_DATA0 + 7'(i), wdata, 0);
      dmi_xfer(harness_pkg::SRC_JTAG, dm_pkg::DTM_READ, `ADDR_DATA0 + 7'(i), 32'h0, 0);
    end
    end_test("jtag select");

    dmi_xfer(harness_pkg::SRC_DTM, dm_pkg::DTM_RSVD, `ADDR_DATA0, 32'hffff_ffff, 0);
    dmi_xfer(harness_pkg::SRC_DTM, dm_pkg::DTM_READ, 7'h20, 32'h0, 0);
    dmi_xfer(harness_pkg::SRC_DTM, dm_pkg::DTM_NOP, `ADDR_DATA0, 32'h1234_5678, 0);
    end_test("response rules");

    dmi_xfer(harness_pkg::SRC_DTM, dm_pkg::DTM_READ, `ADDR_DATA0 + 7'd1, 32'h0, 5);
    dmi_xfer(harness_pkg::SRC_DTM, dm_pkg::DTM_WRITE, `ADDR_DATA0, $random(seed), 4);
    end_test("back-pressure");

    check_bit("sys_rst_no before ndmreset", sys_rst_n, 1'b1);
    dmi_xfer(harness_pkg::SRC_DTM, dm_pkg::DTM_WRITE, `ADDR_DMCONTROL, Dmactive | Ndmreset, 0);
    check_bit("sys_rst_no with ndmreset set", sys_rst_n, 1'b0);
    dmi_xfer(harness_pkg::SRC_DTM, dm_pkg::DTM_READ, `ADDR_DMCONTROL, 32'h0, 0);
    dmi_xfer(harness_pkg::SRC_DTM, dm_pkg::DTM_WRITE, `ADDR_DMCONTROL, Dmactive, 0);
    waited = 0;
    while (!sys_rst_n && waited < 6) begin
      @(negedge clk);
      waited++;
    end
    check_bit("sys_rst_no after ndmreset clears", sys_rst_n, 1'b1);
    for (int i = 0; i < 4; i++) begin
      dmi_xfer(harness_pkg::SRC_DTM, dm_pkg::DTM_READ, `ADDR_DATA0 + 7'(i), 32'h0, 0);
    end
    end_test("ndmreset");

    if (expect_q.size() != 0) begin
      $display("%0d expected responses never arrived", expect_q.size());
      errors++;
    end
    $display("Summary: %0d tests run, %0d errors", tests, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* verification/tb_clk_gen.sv */
// Free-running 20 ns clock; reset is held low for 16 cycles and released on a falling edge
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  localparam int unsigned HalfPeriod = 10;
  localparam int unsigned RstCycles  = 16;

  initial begin
    clk_o = 1'b0;
    forever #(HalfPeriod) clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (RstCycles) @(posedge clk_o);
    // Away from the active edge
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

/* hw/dbg_harness_top.sv */
// Single hart only; src_sel_i must stay stable while a DMI transfer is in flight
`timescale 1ns/1ps

module dbg_harness_top (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  harness_pkg::dmi_src_e src_sel_i,
  // JTAG transport
  input  logic                  jtag_req_valid_i,
  input  dm_pkg::dmi_req_t      jtag_req_i,
  output logic                  jtag_req_ready_o,
  output logic                  jtag_resp_valid_o,
  output dm_pkg::dmi_resp_t     jtag_resp_o,
  input  logic                  jtag_resp_ready_i,
  // DTM transport
  input  logic                  dtm_req_valid_i,
  input  dm_pkg::dmi_req_t      dtm_req_i,
  output logic                  dtm_req_ready_o,
  output logic                  dtm_resp_valid_o,
  output dm_pkg::dmi_resp_t     dtm_resp_o,
  input  logic                  dtm_resp_ready_i,
  // Core side
  output logic                  debug_req_o,
  output logic                  sys_rst_no
);

  logic              tgt_req_valid;
  dm_pkg::dmi_req_t  tgt_req;
  logic              tgt_req_ready;
  logic              tgt_resp_valid;
  logic              tgt_resp_ready;
  dm_pkg::dmi_resp_t tgt_resp;
  dm_pkg::dmi_resp_t resp_next;
  logic              exec;
  logic              dmactive;
  logic              ndmreset;
  logic              haltreq;

  // Response word is shared, only valid is steered
  assign jtag_resp_o = tgt_resp;
  assign dtm_resp_o  = tgt_resp;

  // ----------------------------------------
  // Transport select
  // ----------------------------------------
  dmi_port_mux i_dmi_port_mux (
    .src_sel_i         ( src_sel_i         ),
    .jtag_req_valid_i  ( jtag_req_valid_i  ),
    .jtag_req_i        ( jtag_req_i        ),
    .jtag_resp_ready_i ( jtag_resp_ready_i ),
    .dtm_req_valid_i   ( dtm_req_valid_i   ),
    .dtm_req_i         ( dtm_req_i         ),
    .dtm_resp_ready_i  ( dtm_resp_ready_i  ),
    .tgt_req_ready_i   ( tgt_req_ready     ),
    .tgt_resp_valid_i  ( tgt_resp_valid    ),
    .jtag_req_ready_o  ( jtag_req_ready_o  ),
    .jtag_resp_valid_o ( jtag_resp_valid_o ),
    .dtm_req_ready_o   ( dtm_req_ready_o   ),
    .dtm_resp_valid_o  ( dtm_resp_valid_o  ),
    .tgt_req_valid_o   ( tgt_req_valid     ),
    .tgt_req_o         ( tgt_req           ),
    .tgt_resp_ready_o  ( tgt_resp_ready    )
  );

  // ----------------------------------------
  // DMI target
  // ----------------------------------------
  dmi_ctrl_fsm i_dmi_ctrl_fsm (
    .clk_i        ( clk_i          ),
    .rst_ni       ( rst_ni         ),
    .req_valid_i  ( tgt_req_valid  ),
    .resp_ready_i ( tgt_resp_ready ),
    .resp_next_i  ( resp_next      ),
    .req_ready_o  ( tgt_req_ready  ),
    .exec_o       ( exec           ),
    .resp_valid_o ( tgt_resp_valid ),
    .resp_o       ( tgt_resp       )
  );

  dm_regs i_dm_regs (
    .clk_i       ( clk_i     ),
    .rst_ni      ( rst_ni    ),
    .exec_i      ( exec      ),
    .req_i       ( tgt_req   ),
    .resp_next_o ( resp_next ),
    .dmactive_o  ( dmactive  ),
    .ndmreset_o  ( ndmreset  ),
    .haltreq_o   ( haltreq   )
  );

  // ----------------------------------------
  // Reset and halt request
  // ----------------------------------------
  debug_req_gate i_debug_req_gate (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .haltreq_i   ( haltreq     ),
    .dmactive_i  ( dmactive    ),
    .debug_req_o ( debug_req_o )
  );

  rst_sync i_rst_sync (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .ndmreset_i ( ndmreset   ),
    .sys_rst_no ( sys_rst_no )
  );

endmodule

/* dmi_target/dm_regs.sv */
// Only dmcontrol and data0..data3 are mapped; data registers hold no reset value
`timescale 1ns/1ps

`include "harness_defs.svh"

module dm_regs (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              exec_i,
  input  dm_pkg::dmi_req_t  req_i,
  output dm_pkg::dmi_resp_t resp_next_o,
  output logic              dmactive_o,
  output logic              ndmreset_o,
  output logic              haltreq_o
);

  logic                   dmactive_q;
  logic                   ndmreset_q;
  logic                   haltreq_q;
  logic [`DMI_DATA_W-1:0] data_q [4];
  logic [`DMI_DATA_W-1:0] dmcontrol;
  logic [`DMI_DATA_W-1:0] rdata;
  logic                   hit_dmcontrol;
  logic                   hit_data;
  logic [1:0]             data_idx;
  logic                   wr_en;

  // ----------------------------------------
  // Address decode
  // ----------------------------------------
  assign hit_dmcontrol = (req_i.addr == `ADDR_DMCONTROL);
  assign hit_data      = (req_i.addr >= `ADDR_DATA0) && (req_i.addr <= `ADDR_DATA0 + 7'd3);
  assign data_idx      = 2'(req_i.addr - `ADDR_DATA0);
  assign wr_en         = exec_i && (req_i.op == dm_pkg::DTM_WRITE);

  always_comb begin
    dmcontrol                = '0;
    dmcontrol[`BIT_DMACTIVE] = dmactive_q;
    dmcontrol[`BIT_NDMRESET] = ndmreset_q;
    dmcontrol[`BIT_HALTREQ]  = haltreq_q;
  end

  always_comb begin
    rdata = '0;
    if (hit_dmcontrol) begin
      rdata = dmcontrol;
    end else if (hit_data) begin
      rdata = data_q[data_idx];
    end
  end

  // ----------------------------------------
  // Response for the current request
  // ----------------------------------------
  always_comb begin
    resp_next_o.data = '0;
    resp_next_o.resp = dm_pkg::DMI_OK;
    case (req_i.op)
      dm_pkg::DTM_NOP:   resp_next_o.data = '0;
      dm_pkg::DTM_READ:  resp_next_o.data = rdata;
      dm_pkg::DTM_WRITE: resp_next_o.data = '0;
      default:           resp_next_o.resp = dm_pkg::DMI_FAILED;
    endcase
  end

  // ----------------------------------------
  // Register updates
  // ----------------------------------------
  // Debug module state survives its own ndmreset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dmactive_q <= 1'b0;
      ndmreset_q <= 1'b0;
      haltreq_q  <= 1'b0;
    end else if (wr_en && hit_dmcontrol) begin
      dmactive_q <= req_i.data[`BIT_DMACTIVE];
      ndmreset_q <= req_i.data[`BIT_NDMRESET];
      haltreq_q  <= req_i.data[`BIT_HALTREQ];
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en && hit_data) begin
      data_q[data_idx] <= req_i.data;
    end
  end

  assign dmactive_o = dmactive_q;
  assign ndmreset_o = ndmreset_q;
  assign haltreq_o  = haltreq_q;

endmodule

/* dmi_target/dmi_ctrl_fsm.sv */
// One outstanding request; response valid comes exactly one cycle after acceptance
`timescale 1ns/1ps

module dmi_ctrl_fsm (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              req_valid_i,
  input  logic              resp_ready_i,
  input  dm_pkg::dmi_resp_t resp_next_i,
  output logic              req_ready_o,
  output logic              exec_o,
  output logic              resp_valid_o,
  output dm_pkg::dmi_resp_t resp_o
);

  harness_pkg::dmi_state_e state_d;
  harness_pkg::dmi_state_e state_q;
  dm_pkg::dmi_resp_t       resp_q;

  assign req_ready_o  = (state_q == harness_pkg::IDLE);
  assign resp_valid_o = (state_q == harness_pkg::RESP);
  assign resp_o       = resp_q;

  // Accept strobe doubles as the register block's execute
  assign exec_o = req_ready_o & req_valid_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      harness_pkg::IDLE: begin
        if (exec_o) begin
          state_d = harness_pkg::RESP;
        end
      end
      harness_pkg::RESP: begin
        // Hold until the requester takes it
        if (resp_ready_i) begin
          state_d = harness_pkg::IDLE;
        end
      end
      default: state_d = harness_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= harness_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Captured once per request, stable under back-pressure
  always_ff @(posedge clk_i) begin
    if (exec_o) begin
      resp_q <= resp_next_i;
    end
  end

endmodule

/* hw/debug_req_gate.sv */
// Window restarts only on power-on reset; ndmreset does not reopen it
`timescale 1ns/1ps

`include "harness_defs.svh"

module debug_req_gate (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic haltreq_i,
  input  logic dmactive_i,
  output logic debug_req_o
);

  localparam int unsigned CntW = $clog2(`DMI_DEL_CYCLES + 1);

  logic [CntW-1:0] del_cnt_q;
  logic            window_open;

  // Boot code gets this window before any halt
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      del_cnt_q <= CntW'(`DMI_DEL_CYCLES);
    end else if (del_cnt_q != '0) begin
      del_cnt_q <= del_cnt_q - 1'b1;
    end
  end

  assign window_open = (del_cnt_q == '0);

  assign debug_req_o = window_open & haltreq_i & dmactive_i;

endmodule

/* hw/rst_sync.sv */
// Assertion is asynchronous from either source; release is synchronous, needs 2+ stages
`timescale 1ns/1ps

`include "harness_defs.svh"

module rst_sync (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic ndmreset_i,
  output logic sys_rst_no
);

  logic                        rst_comb_n;
  logic [`RST_SYNC_STAGES-1:0] sync_q;

  // Power-on reset or debugger-driven reset
  assign rst_comb_n = rst_ni & ~ndmreset_i;

  always_ff @(posedge clk_i or negedge rst_comb_n) begin
    if (!rst_comb_n) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[`RST_SYNC_STAGES-2:0], 1'b1};
    end
  end

  assign sys_rst_no = sync_q[`RST_SYNC_STAGES-1];

endmodule

/* hw/dmi_port_mux.sv */
// Purely combinational; the unselected transport sees ready but never a response valid
`timescale 1ns/1ps

module dmi_port_mux (
  input  harness_pkg::dmi_src_e src_sel_i,
  input  logic                  jtag_req_valid_i,
  input  dm_pkg::dmi_req_t      jtag_req_i,
  input  logic                  jtag_resp_ready_i,
  input  logic                  dtm_req_valid_i,
  input  dm_pkg::dmi_req_t      dtm_req_i,
  input  logic                  dtm_resp_ready_i,
  input  logic                  tgt_req_ready_i,
  input  logic                  tgt_resp_valid_i,
  output logic                  jtag_req_ready_o,
  output logic                  jtag_resp_valid_o,
  output logic                  dtm_req_ready_o,
  output logic                  dtm_resp_valid_o,
  output logic                  tgt_req_valid_o,
  output dm_pkg::dmi_req_t      tgt_req_o,
  output logic                  tgt_resp_ready_o
);

  logic jtag_sel;

  assign jtag_sel = (src_sel_i == harness_pkg::SRC_JTAG);

  // Request side from the owner only
  assign tgt_req_valid_o  = jtag_sel ? jtag_req_valid_i  : dtm_req_valid_i;
  assign tgt_req_o        = jtag_sel ? jtag_req_i        : dtm_req_i;
  assign tgt_resp_ready_o = jtag_sel ? jtag_resp_ready_i : dtm_resp_ready_i;

  // Ready goes to both sides
  assign jtag_req_ready_o = tgt_req_ready_i;
  assign dtm_req_ready_o  = tgt_req_ready_i;

  assign jtag_resp_valid_o = jtag_sel ? tgt_resp_valid_i : 1'b0;
  assign dtm_resp_valid_o  = jtag_sel ? 1'b0 : tgt_resp_valid_i;

endmodule

/* common/harness_pkg.sv */
// Harness-level types; transport select is a static level, not switched mid-transfer
package harness_pkg;

  // ----------------------------------------
  // Transport select
  // ----------------------------------------
  typedef enum logic {
    SRC_DTM  = 1'b0,
    SRC_JTAG = 1'b1
  } dmi_src_e;

  // ----------------------------------------
  // DMI handshake FSM
  // ----------------------------------------
  // IDLE waits for a request, RESP holds the response
  typedef enum logic {
    IDLE = 1'b0,
    RESP = 1'b1
  } dmi_state_e;

endpackage

/* common/dm_pkg.sv */
// DMI request and response words; only NOP, READ and WRITE ops are meaningful
`include "harness_defs.svh"

package dm_pkg;

  // ----------------------------------------
  // Operation and response codes
  // ----------------------------------------
  typedef enum logic [1:0] {
    DTM_NOP   = 2'h0,
    DTM_READ  = 2'h1,
    DTM_WRITE = 2'h2,
    DTM_RSVD  = 2'h3
  } dtm_op_e;

  // Code 1 is unused by this target
  typedef enum logic [1:0] {
    DMI_OK     = 2'h0,
    DMI_FAILED = 2'h2
  } dmi_resp_code_e;

  // ----------------------------------------
  // Transfer words
  // ----------------------------------------
  typedef struct packed {
    logic [`DMI_ADDR_W-1:0] addr;
    dtm_op_e                op;
    logic [`DMI_DATA_W-1:0] data;
  } dmi_req_t;

  typedef struct packed {
    logic [`DMI_DATA_W-1:0] data;
    dmi_resp_code_e         resp;
  } dmi_resp_t;

endpackage

/* common/harness_defs.svh */
// DMI widths are fixed by the debug spec; changing them breaks the dm_pkg word layout
`ifndef HARNESS_DEFS_SVH
`define HARNESS_DEFS_SVH

// DMI word format
`define DMI_ADDR_W 7
`define DMI_DATA_W 32

// Halt requests held back this many cycles after power-on reset
`define DMI_DEL_CYCLES 500
// Must be 2 or more
`define RST_SYNC_STAGES 2

// data1..data3 follow data0 in the register map
`define ADDR_DATA0     7'h04
`define ADDR_DMCONTROL 7'h10

// dmcontrol bit positions
`define BIT_DMACTIVE 0
`define BIT_NDMRESET 1
`define BIT_HALTREQ  31

`endif
